//--- design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 23;
    localparam int num_banks = 4;

    // address field widths, row takes what is left above bank and column
    localparam int bank_width = $clog2(num_banks);
    localparam int col_width = 8;
    localparam int row_width = addr_width - bank_width - col_width;

    typedef logic [bank_width-1:0] bank_t;
    typedef logic [row_width-1:0] row_t;
    typedef logic [col_width-1:0] col_t;

    // command spacing count
    typedef logic [3:0] delay_t;

    typedef struct packed {
        row_t row;
        bank_t bank;
        col_t col;
    } user_addr_t;

    // levels of cs, ras, cas, we
    typedef enum logic [3:0] {
        cmd_unselected = 4'b1000,
        cmd_nop        = 4'b0111,
        cmd_active     = 4'b0011,
        cmd_read       = 4'b0101,
        cmd_write      = 4'b0100,
        cmd_terminate  = 4'b0110,
        cmd_precharge  = 4'b0010,
        cmd_refresh    = 4'b0001
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        st_init,
        st_wait_delay,
        st_idle,
        st_refresh,
        st_activate,
        st_read,
        st_read_res,
        st_write,
        st_precharge
    } ctrl_state_e;

    // one cycle worth of sdram pin values
    typedef struct packed {
        sdram_cmd_e cmd;
        bank_t bank;
        row_t addr;
        logic [data_width-1:0] dq;
        logic dq_en;
    } sdram_pins_t;

    typedef struct packed {
        logic rw;
        user_addr_t addr;
        logic [data_width-1:0] data;
    } user_req_t;

endpackage

`default_nettype wire

//--- design/sdram_timer.sv
`default_nettype none

module sdram_timer #(
    parameter int unsigned refresh_interval = 750
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic delay_load,
    input  wire sdram_pkg::delay_t delay_value,
    input  wire logic refresh_ack,
    output logic delay_done,
    output logic refresh_due
);

    import sdram_pkg::*;

    localparam int ref_width = $clog2(refresh_interval + 1);

    delay_t delay_q;
    logic [ref_width-1:0] ref_cnt_q;

    assign delay_done = (delay_q == '0);

    // command spacing, counts down to zero and stops
    always_ff @(posedge clk) begin
        if (rst) begin
            delay_q <= '0;
        end else if (delay_load) begin
            delay_q <= delay_value;
        end else if (!delay_done) begin
            delay_q <= delay_q - 1'b1;
        end
    end

    // free running, wraps once per interval
    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt_q <= '0;
        end else if (ref_cnt_q == ref_width'(refresh_interval)) begin
            ref_cnt_q <= '0;
        end else begin
            ref_cnt_q <= ref_cnt_q + 1'b1;
        end
    end

    // due flag stays up until the fsm answers it
    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_due <= 1'b0;
        end else if (ref_cnt_q == ref_width'(refresh_interval)) begin
            refresh_due <= 1'b1;
        end else if (refresh_ack) begin
            refresh_due <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/sdram_row_tracker.sv
`default_nettype none

module sdram_row_tracker (
    input  wire logic clk,
    input  wire logic rst,
    input  wire sdram_pkg::bank_t cmd_bank,
    input  wire sdram_pkg::row_t cmd_row,
    input  wire logic open_row,
    input  wire logic close_bank,
    input  wire logic close_all,
    output logic row_open,
    output logic row_hit
);

    import sdram_pkg::*;

    logic [num_banks-1:0] open_q;
    row_t rows_q [num_banks];

    assign row_open = open_q[cmd_bank];
    assign row_hit = row_open && (rows_q[cmd_bank] == cmd_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (close_all) begin
            open_q <= '0;
        end else if (close_bank) begin
            open_q[cmd_bank] <= 1'b0;
        end else if (open_row) begin
            open_q[cmd_bank] <= 1'b1;
        end
    end

    // row only matters while the open bit is set
    always_ff @(posedge clk) begin
        if (open_row) begin
            rows_q[cmd_bank] <= cmd_row;
        end
    end

endmodule

`default_nettype wire

//--- design/sdram_request_slot.sv
`default_nettype none

module sdram_request_slot (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic in_valid,
    input  wire logic rw,
    input  wire sdram_pkg::user_addr_t user_addr,
    input  wire logic [sdram_pkg::data_width-1:0] data_in,
    input  wire logic take,
    output sdram_pkg::user_req_t req,
    output logic pending,
    output logic busy
);

    import sdram_pkg::*;

    logic full_q;

    // comes out of reset full, init frees it
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b1;
        end else if (take) begin
            full_q <= 1'b0;
        end else if (in_valid) begin
            full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !full_q) begin
            req.rw <= rw;
            req.addr <= user_addr;
            req.data <= data_in;
        end
    end

    assign pending = full_q;
    assign busy = full_q;

endmodule

`default_nettype wire

//--- design/sdram_pin_driver.sv
`default_nettype none

module sdram_pin_driver (
    input  wire logic clk,
    input  wire logic rst,
    input  wire sdram_pkg::sdram_pins_t pins_next,
    input  wire logic cke,
    input  wire logic capture,
    input  wire logic [sdram_pkg::data_width-1:0] sdram_dqi,
    output logic sdram_cke,
    output logic sdram_cs,
    output logic sdram_ras,
    output logic sdram_cas,
    output logic sdram_we,
    output sdram_pkg::bank_t sdram_ba,
    output logic [sdram_pkg::row_width-1:0] sdram_a,
    output logic [sdram_pkg::data_width-1:0] sdram_dqo,
    output logic sdram_dq_en,
    output logic [sdram_pkg::data_width-1:0] data_out,
    output logic out_valid
);

    import sdram_pkg::*;

    sdram_cmd_e cmd_q;
    logic [data_width-1:0] dqi_q;

    assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = cmd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q <= cmd_nop;
            sdram_cke <= 1'b0;
            sdram_dq_en <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            cmd_q <= pins_next.cmd;
            sdram_cke <= cke;
            sdram_dq_en <= pins_next.dq_en;
            out_valid <= capture;
        end
    end

    // address and data follow the command
    always_ff @(posedge clk) begin
        sdram_ba <= pins_next.bank;
        sdram_a <= pins_next.addr;
        sdram_dqo <= pins_next.dq;
        dqi_q <= sdram_dqi;
        if (capture) begin
            data_out <= dqi_q;
        end
    end

endmodule

`default_nettype wire

//--- design/sdram_ctrl_fsm.sv
`default_nettype none

module sdram_ctrl_fsm #(
    parameter int unsigned t_cas = 2,
    parameter int unsigned t_act = 2,
    parameter int unsigned t_pre = 2,
    parameter int unsigned t_ref = 6
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire sdram_pkg::user_req_t req,
    input  wire logic pending,
    input  wire logic row_open,
    input  wire logic row_hit,
    input  wire logic delay_done,
    input  wire logic refresh_due,
    output logic take,
    output logic refresh_ack,
    output logic delay_load,
    output sdram_pkg::delay_t delay_value,
    output logic open_row,
    output logic close_bank,
    output logic close_all,
    output sdram_pkg::bank_t cmd_bank,
    output sdram_pkg::row_t cmd_row,
    output sdram_pkg::sdram_pins_t pins_next,
    output logic cke,
    output logic capture
);

    import sdram_pkg::*;

    ctrl_state_e state_q, state_d;
    ctrl_state_e next_q, next_d;
    logic pre_all_q, pre_all_d;

    // request being worked on
    logic rw_q;
    user_addr_t addr_q;
    logic [data_width-1:0] data_q;

    // column sits two bits up on the address pins
    row_t col_pins;
    assign col_pins = row_t'({addr_q.col, 2'b00});

    // tracker looks at the waiting request while idle
    assign cmd_bank = (state_q == st_idle) ? req.addr.bank : addr_q.bank;
    assign cmd_row = (state_q == st_idle) ? req.addr.row : addr_q.row;

    assign cke = (state_q != st_init);

    always_comb begin
        state_d = state_q;
        next_d = next_q;
        pre_all_d = pre_all_q;
        take = 1'b0;
        refresh_ack = 1'b0;
        delay_load = 1'b0;
        delay_value = '0;
        open_row = 1'b0;
        close_bank = 1'b0;
        close_all = 1'b0;
        capture = 1'b0;
        pins_next = '0;
        pins_next.cmd = cmd_nop;
        pins_next.dq = data_q;

        case (state_q)
            st_init: begin
                // frees the slot so busy drops
                take = 1'b1;
                delay_load = 1'b1;
                next_d = st_idle;
                state_d = st_wait_delay;
            end
            st_wait_delay: begin
                if (delay_done) begin
                    state_d = next_q;
                end
            end
            st_idle: begin
                if (refresh_due) begin
                    refresh_ack = 1'b1;
                    pre_all_d = 1'b1;
                    next_d = st_refresh;
                    state_d = st_precharge;
                end else if (pending) begin
                    take = 1'b1;
                    if (row_hit) begin
                        if (req.rw) begin
                            state_d = st_write;
                        end else begin
                            state_d = st_read;
                        end
                    end else if (row_open) begin
                        // other row open in this bank
                        pre_all_d = 1'b0;
                        next_d = st_activate;
                        state_d = st_precharge;
                    end else begin
                        state_d = st_activate;
                    end
                end
            end
            st_refresh: begin
                pins_next.cmd = cmd_refresh;
                delay_load = 1'b1;
                delay_value = delay_t'(t_ref);
                next_d = st_idle;
                state_d = st_wait_delay;
            end
            st_activate: begin
                pins_next.cmd = cmd_active;
                pins_next.bank = addr_q.bank;
                pins_next.addr = addr_q.row;
                open_row = 1'b1;
                delay_load = 1'b1;
                delay_value = delay_t'(t_act);
                if (rw_q) begin
                    next_d = st_write;
                end else begin
                    next_d = st_read;
                end
                state_d = st_wait_delay;
            end
            st_read: begin
                pins_next.cmd = cmd_read;
                pins_next.bank = addr_q.bank;
                pins_next.addr = col_pins;
                delay_load = 1'b1;
                delay_value = delay_t'(t_cas);
                next_d = st_read_res;
                state_d = st_wait_delay;
            end
            st_read_res: begin
                capture = 1'b1;
                state_d = st_idle;
            end
            st_write: begin
                pins_next.cmd = cmd_write;
                pins_next.bank = addr_q.bank;
                pins_next.addr = col_pins;
                pins_next.dq_en = 1'b1;
                state_d = st_idle;
            end
            st_precharge: begin
                pins_next.cmd = cmd_precharge;
                pins_next.bank = addr_q.bank;
                // a10 selects all banks
                pins_next.addr[10] = pre_all_q;
                close_all = pre_all_q;
                close_bank = !pre_all_q;
                delay_load = 1'b1;
                delay_value = delay_t'(t_pre);
                state_d = st_wait_delay;
            end
            default: begin
                state_d = st_init;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_init;
            next_q <= st_idle;
            pre_all_q <= 1'b0;
        end else begin
            state_q <= state_d;
            next_q <= next_d;
            pre_all_q <= pre_all_d;
        end
    end

    // latch the request when it leaves the slot
    always_ff @(posedge clk) begin
        if (take && state_q == st_idle) begin
            rw_q <= req.rw;
            addr_q <= req.addr;
            data_q <= req.data;
        end
    end

endmodule

`default_nettype wire

//--- design/sdram_ctrl_top.sv
`default_nettype none

module sdram_ctrl_top #(
    parameter int unsigned t_cas = 2,
    parameter int unsigned t_act = 2,
    parameter int unsigned t_pre = 2,
    parameter int unsigned t_ref = 6,
    parameter int unsigned refresh_interval = 750
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic in_valid,
    input  wire logic rw,
    input  wire sdram_pkg::user_addr_t user_addr,
    input  wire logic [sdram_pkg::data_width-1:0] data_in,
    input  wire logic [sdram_pkg::data_width-1:0] sdram_dqi,
    output logic busy,
    output logic [sdram_pkg::data_width-1:0] data_out,
    output logic out_valid,
    output logic sdram_cke,
    output logic sdram_cs,
    output logic sdram_ras,
    output logic sdram_cas,
    output logic sdram_we,
    output sdram_pkg::bank_t sdram_ba,
    output logic [sdram_pkg::row_width-1:0] sdram_a,
    output logic [sdram_pkg::data_width-1:0] sdram_dqo,
    output logic sdram_dq_en
);

    import sdram_pkg::*;

    user_req_t req;
    logic pending;
    logic take;

    logic row_open;
    logic row_hit;
    logic open_row;
    logic close_bank;
    logic close_all;
    bank_t cmd_bank;
    row_t cmd_row;

    logic delay_load;
    delay_t delay_value;
    logic delay_done;
    logic refresh_due;
    logic refresh_ack;

    sdram_pins_t pins_next;
    logic cke;
    logic capture;

    sdram_request_slot slot_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .rw       (rw),
        .user_addr(user_addr),
        .data_in  (data_in),
        .take     (take),
        .req      (req),
        .pending  (pending),
        .busy     (busy)
    );

    sdram_ctrl_fsm #(
        .t_cas(t_cas),
        .t_act(t_act),
        .t_pre(t_pre),
        .t_ref(t_ref)
    ) fsm_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .pending    (pending),
        .row_open   (row_open),
        .row_hit    (row_hit),
        .delay_done (delay_done),
        .refresh_due(refresh_due),
        .take       (take),
        .refresh_ack(refresh_ack),
        .delay_load (delay_load),
        .delay_value(delay_value),
        .open_row   (open_row),
        .close_bank (close_bank),
        .close_all  (close_all),
        .cmd_bank   (cmd_bank),
        .cmd_row    (cmd_row),
        .pins_next  (pins_next),
        .cke        (cke),
        .capture    (capture)
    );

    sdram_timer #(
        .refresh_interval(refresh_interval)
    ) timer_i (
        .clk        (clk),
        .rst        (rst),
        .delay_load (delay_load),
        .delay_value(delay_value),
        .refresh_ack(refresh_ack),
        .delay_done (delay_done),
        .refresh_due(refresh_due)
    );

    sdram_row_tracker tracker_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_bank  (cmd_bank),
        .cmd_row   (cmd_row),
        .open_row  (open_row),
        .close_bank(close_bank),
        .close_all (close_all),
        .row_open  (row_open),
        .row_hit   (row_hit)
    );

    sdram_pin_driver pins_i (
        .clk        (clk),
        .rst        (rst),
        .pins_next  (pins_next),
        .cke        (cke),
        .capture    (capture),
        .sdram_dqi  (sdram_dqi),
        .sdram_cke  (sdram_cke),
        .sdram_cs   (sdram_cs),
        .sdram_ras  (sdram_ras),
        .sdram_cas  (sdram_cas),
        .sdram_we   (sdram_we),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .sdram_dqo  (sdram_dqo),
        .sdram_dq_en(sdram_dq_en),
        .data_out   (data_out),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

//--- test/sdram_mem_model.sv
`default_nettype none

module sdram_mem_model #(
    parameter int unsigned refresh_interval = 750
) (
    input  wire logic clk,
    input  wire logic cke,
    input  wire logic cs,
    input  wire logic ras,
    input  wire logic cas,
    input  wire logic we,
    input  wire sdram_pkg::bank_t ba,
    input  wire logic [sdram_pkg::row_width-1:0] a,
    input  wire logic [sdram_pkg::data_width-1:0] dqo,
    input  wire logic dq_en,
    output logic [sdram_pkg::data_width-1:0] dqi,
    output logic protocol_error
);

    timeunit 1ns;
    timeprecision 1ps;

    import sdram_pkg::*;

    // longest allowed stretch without a refresh
    localparam int max_gap = refresh_interval + 40;

    logic [num_banks-1:0] bank_open;
    row_t open_rows [num_banks];
    logic [data_width-1:0] mem [logic [addr_width-1:0]];
    logic pre_all_seen;
    int since_refresh;
    sdram_cmd_e cmd;
    logic [addr_width-1:0] key;

    initial begin
        dqi = '0;
        protocol_error = 1'b0;
        bank_open = '0;
        pre_all_seen = 1'b0;
        since_refresh = 0;
    end

    task automatic flag_error(input string what);
        $display("Protocol error at %0t ns: %s", $time, what);
        protocol_error = 1'b1;
    endtask

    always @(posedge clk) begin
        cmd = sdram_cmd_e'({cs, ras, cas, we});
        if (cke === 1'b1) begin
            since_refresh = since_refresh + 1;
            if (since_refresh > max_gap) begin
                flag_error("no REFRESH within the refresh interval");
            end
            // key is the user address with row, bank and column from the top
            key = {open_rows[ba], ba, a[col_width+1:2]};
            case (cmd)
                cmd_active: begin
                    if (bank_open[ba]) begin
                        flag_error("ACTIVATE to a bank that already has an open row");
                    end
                    bank_open[ba] <= 1'b1;
                    open_rows[ba] <= a;
                    pre_all_seen <= 1'b0;
                end
                cmd_read: begin
                    if (!bank_open[ba]) begin
                        flag_error("READ to a bank with no open row");
                    end
                    dqi <= mem.exists(key) ? mem[key] : '0;
                end
                cmd_write: begin
                    if (!bank_open[ba]) begin
                        flag_error("WRITE to a bank with no open row");
                    end
                    if (dq_en !== 1'b1) begin
                        flag_error("WRITE while the controller does not drive the data bus");
                    end
                    mem[key] = dqo;
                end
                cmd_precharge: begin
                    if (a[10]) begin
                        bank_open <= '0;
                        pre_all_seen <= 1'b1;
                    end else begin
                        bank_open[ba] <= 1'b0;
                    end
                end
                cmd_refresh: begin
                    if (!pre_all_seen || bank_open != '0) begin
                        flag_error("REFRESH without a precharge of all banks before it");
                    end
                    pre_all_seen <= 1'b0;
                    since_refresh = 0;
                end
                cmd_nop: begin
                end
                default: begin
                    flag_error("unexpected command on the SDRAM pins");
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- test/tb_sdram_ctrl.sv
`default_nettype none

module tb_sdram_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import sdram_pkg::*;

    localparam int clk_period = 20;
    localparam int reset_cycles = 10;
    localparam int num_requests = 400;
    localparam int cycles_per_request = 40;
    localparam int refresh_interval = 750;
    localparam longint timeout_ns =
        longint'(num_requests) * cycles_per_request * clk_period + reset_cycles * clk_period;

    logic clk;
    logic rst;
    logic in_valid;
    logic rw;
    user_addr_t user_addr;
    logic [data_width-1:0] data_in;
    logic [data_width-1:0] sdram_dqi;
    logic busy;
    logic [data_width-1:0] data_out;
    logic out_valid;
    logic sdram_cke;
    logic sdram_cs;
    logic sdram_ras;
    logic sdram_cas;
    logic sdram_we;
    bank_t sdram_ba;
    logic [row_width-1:0] sdram_a;
    logic [data_width-1:0] sdram_dqo;
    logic sdram_dq_en;
    logic protocol_error;

    integer seed;
    int error_count;

    // reference memory and outstanding work, in request order
    logic [data_width-1:0] ref_mem [logic [addr_width-1:0]];
    logic [data_width-1:0] read_data_q [$];
    user_req_t read_cmd_q [$];
    user_req_t write_q [$];

    sdram_ctrl_top sdram_ctrl_top_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .rw         (rw),
        .user_addr  (user_addr),
        .data_in    (data_in),
        .sdram_dqi  (sdram_dqi),
        .busy       (busy),
        .data_out   (data_out),
        .out_valid  (out_valid),
        .sdram_cke  (sdram_cke),
        .sdram_cs   (sdram_cs),
        .sdram_ras  (sdram_ras),
        .sdram_cas  (sdram_cas),
        .sdram_we   (sdram_we),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .sdram_dqo  (sdram_dqo),
        .sdram_dq_en(sdram_dq_en)
    );

    sdram_mem_model #(
        .refresh_interval(refresh_interval)
    ) mem_i (
        .clk           (clk),
        .cke           (sdram_cke),
        .cs            (sdram_cs),
        .ras           (sdram_ras),
        .cas           (sdram_cas),
        .we            (sdram_we),
        .ba            (sdram_ba),
        .a             (sdram_a),
        .dqo           (sdram_dqo),
        .dq_en         (sdram_dq_en),
        .dqi           (sdram_dqi),
        .protocol_error(protocol_error)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        error_count++;
        $display("Error at %0t ns: %s", $time, reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    // two rows, four banks, four columns so hits and misses both show up
    task automatic issue_request();
        user_req_t r;
        logic [31:0] rnd;
        rnd = $random(seed);
        r.rw = rnd[0];
        r.addr.row = rnd[1] ? 13'h0a5 : 13'h1c3;
        r.addr.bank = rnd[3:2];
        r.addr.col = {rnd[5:4], 6'h09};
        r.data = $random(seed);
        in_valid = 1'b1;
        rw = r.rw;
        user_addr = r.addr;
        data_in = r.data;
        if (r.rw) begin
            ref_mem[r.addr] = r.data;
            write_q.push_back(r);
        end else begin
            read_cmd_q.push_back(r);
            read_data_q.push_back(ref_mem.exists(r.addr) ? ref_mem[r.addr] : '0);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (out_valid === 1'b1) begin
            if (read_data_q.size() == 0) begin
                abort_run("out_valid without an outstanding read request");
            end else begin
                check_value("data_out", data_out, read_data_q.pop_front());
            end
        end
    end

    // READ and WRITE on the pins against the request that caused them
    always @(posedge clk) begin : pin_monitor
        user_req_t r;
        if (sdram_cke === 1'b1 && {sdram_cs, sdram_ras, sdram_cas, sdram_we} == cmd_write) begin
            if (write_q.size() == 0) begin
                abort_run("WRITE command with no write request outstanding");
            end else begin
                r = write_q.pop_front();
                check_value("sdram_dqo", sdram_dqo, r.data);
                check_value("sdram_dq_en", sdram_dq_en, 1'b1);
                check_value("sdram_ba", sdram_ba, r.addr.bank);
                check_value("sdram_a", sdram_a, {r.addr.col, 2'b00});
                check_value("open row", mem_i.open_rows[sdram_ba], r.addr.row);
            end
        end
        if (sdram_cke === 1'b1 && {sdram_cs, sdram_ras, sdram_cas, sdram_we} == cmd_read) begin
            if (read_cmd_q.size() == 0) begin
                abort_run("READ command with no read request outstanding");
            end else begin
                r = read_cmd_q.pop_front();
                check_value("sdram_ba", sdram_ba, r.addr.bank);
                check_value("sdram_a", sdram_a, {r.addr.col, 2'b00});
                check_value("open row", mem_i.open_rows[sdram_ba], r.addr.row);
            end
        end
    end

    always @(posedge protocol_error) begin
        abort_run("memory model reported a protocol error");
    end

    initial begin
        #(timeout_ns);
        abort_run("timeout, requests did not complete in time");
    end

    initial begin : stimulus
        logic [31:0] junk;
        int cycles;
        seed = 82;
        error_count = 0;
        rst = 1'b1;
        in_valid = 1'b0;
        rw = 1'b0;
        user_addr = '0;
        data_in = '0;
        repeat (reset_cycles) @(posedge clk);
        // pin levels while reset is held
        check_value("sdram_cke", sdram_cke, 1'b0);
        check_value("sdram_cmd", {sdram_cs, sdram_ras, sdram_cas, sdram_we}, cmd_nop);
        check_value("sdram_dq_en", sdram_dq_en, 1'b0);
        check_value("out_valid", out_valid, 1'b0);
        check_value("busy", busy, 1'b1);
        #2;
        rst = 1'b0;
        cycles = 0;
        while (busy && cycles < 4) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        check_value("busy", busy, 1'b0);

        for (int i = 0; i < num_requests; i++) begin
            while (busy) begin
                // requests offered while busy must be dropped
                junk = $random(seed);
                in_valid = junk[0] & junk[1];
                rw = junk[2];
                user_addr = user_addr_t'(junk[25:3]);
                data_in = $random(seed);
                @(posedge clk);
                #2;
            end
            issue_request();
        end

        while (read_data_q.size() != 0 || write_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
design/sdram_pkg.sv
design/sdram_timer.sv
design/sdram_row_tracker.sv
design/sdram_request_slot.sv
design/sdram_pin_driver.sv
design/sdram_ctrl_fsm.sv
design/sdram_ctrl_top.sv
test/sdram_mem_model.sv
test/tb_sdram_ctrl.sv

//--- Bender.yml
package:
  name: sdram_ctrl

sources:
  - files:
      - design/sdram_pkg.sv
      - design/sdram_timer.sv
      - design/sdram_row_tracker.sv
      - design/sdram_request_slot.sv
      - design/sdram_pin_driver.sv
      - design/sdram_ctrl_fsm.sv
      - design/sdram_ctrl_top.sv
  - target: test
    files:
      - test/sdram_mem_model.sv
      - test/tb_sdram_ctrl.sv
